/* logic/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int PC_BITS   = 16;
    localparam int REG_IDX_W = 5;
    localparam int CSR_IDX_W = 12;
    localparam int FUNCT3_W  = 3;

    // major opcode, instruction bits 6:2
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // low bits of every 32-bit word
    localparam logic [1:0] OPC_FULL = 2'b11;

    // funct12 of the privileged system words
    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_MRET   = 12'h302;

    typedef struct packed {
        logic add_override;
        logic op2_inverse;
        logic sh_ar;
        logic group_mux;
        logic div_mux;
    } alu_ctrl_t;

    // one-hot
    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    // same encoding as funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

endpackage

/* logic/rv_decode_if.sv */
interface decode_bus_if;
    logic [rv_decode_pkg::XLEN-1:0]    instr;
    logic [rv_decode_pkg::PC_BITS-1:1] pc;
    logic [rv_decode_pkg::PC_BITS-1:1] pc_next;
    logic                              valid;

    modport src (output instr, output pc, output pc_next, output valid);
    modport dst (input instr, input pc, input pc_next, input valid);
endinterface

interface class_if;
    logic                    supported;
    rv_decode_pkg::alu_ctrl_t alu_ctrl;
    rv_decode_pkg::res_src_t  res_src;
    logic                    reg_write;
    logic                    op1_pc;
    logic                    op2_imm;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    is_store;
    logic                    is_mret;
    logic                    is_ebreak;
    logic                    csr_req;
    rv_decode_pkg::csr_op_t   csr_op;
    logic                    csr_imm_sel;

    modport src (output supported, alu_ctrl, res_src, reg_write, op1_pc, op2_imm,
                 is_branch, is_jal, is_jalr, is_store, is_mret, is_ebreak,
                 csr_req, csr_op, csr_imm_sel);
    modport dst (input supported, alu_ctrl, res_src, reg_write, op1_pc, op2_imm,
                 is_branch, is_jal, is_jalr, is_store, is_mret, is_ebreak,
                 csr_req, csr_op, csr_imm_sel);
endinterface

interface operand_if;
    logic [rv_decode_pkg::REG_IDX_W-1:0] rs1;
    logic [rv_decode_pkg::REG_IDX_W-1:0] rs2;
    logic [rv_decode_pkg::REG_IDX_W-1:0] rd;
    logic [rv_decode_pkg::XLEN-1:0]      imm;
    logic [rv_decode_pkg::FUNCT3_W-1:0]  funct3;
    logic [rv_decode_pkg::CSR_IDX_W-1:0] csr_idx;
    logic [rv_decode_pkg::REG_IDX_W-1:0] csr_imm;

    modport src (output rs1, rs2, rd, imm, funct3, csr_idx, csr_imm);
    modport dst (input rs1, rs2, rd, imm, funct3, csr_idx, csr_imm);
endinterface

/* logic/rv_fetch_latch.sv */
module rv_fetch_latch
(
    input  logic                              clk,
    input  logic                              i_arst_n,
    input  logic                              i_stall,
    input  logic                              i_flush,
    input  logic                              i_ready,
    input  logic [rv_decode_pkg::XLEN-1:0]    i_instruction,
    input  logic [rv_decode_pkg::PC_BITS-1:1] i_pc,
    input  logic [rv_decode_pkg::PC_BITS-1:1] i_pc_next,
    decode_bus_if.src                         o_bus
);

    // flush wins over stall, stall holds everything
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_bus.valid <= 1'b0;
            o_bus.instr <= '0;
        end
        else if (i_flush)
        begin
            o_bus.valid <= 1'b0;
            // cleared so stale fields cannot decode
            o_bus.instr <= '0;
        end
        else if (!i_stall)
        begin
            o_bus.valid <= i_ready;
            o_bus.instr <= i_instruction;
        end
    end

    // pc pair follows the word
    always_ff @(posedge clk)
    begin
        if (!i_flush && !i_stall)
        begin
            o_bus.pc      <= i_pc;
            o_bus.pc_next <= i_pc_next;
        end
    end

endmodule

/* logic/rv_class_decode.sv */
module rv_class_decode
(
    decode_bus_if.dst i_bus,
    class_if.src      o_cls
);

    logic [4:0]  op;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        inst_full;

    logic grp_load, grp_op_imm, grp_auipc, grp_store, grp_op;
    logic grp_arith, grp_mul, grp_lui, grp_branch, grp_jal, grp_jalr;
    logic grp_sys, inst_trap, inst_ecall, inst_ebreak, inst_mret, inst_csr;
    logic supported;

    logic alu_add, alu_inv_force, alu_inv_clear;

    assign op        = i_bus.instr[6:2];
    assign funct3    = i_bus.instr[14:12];
    assign funct7    = i_bus.instr[31:25];
    assign funct12   = i_bus.instr[31:20];
    assign inst_full = (i_bus.instr[1:0] == rv_decode_pkg::OPC_FULL);

    assign grp_load   = inst_full & (op == rv_decode_pkg::OPC_LOAD);
    assign grp_op_imm = inst_full & (op == rv_decode_pkg::OPC_OP_IMM);
    assign grp_auipc  = inst_full & (op == rv_decode_pkg::OPC_AUIPC);
    assign grp_store  = inst_full & (op == rv_decode_pkg::OPC_STORE);
    assign grp_op     = inst_full & (op == rv_decode_pkg::OPC_OP);
    assign grp_arith  = grp_op & !funct7[0];
    assign grp_mul    = grp_op & funct7[0];
    assign grp_lui    = inst_full & (op == rv_decode_pkg::OPC_LUI);
    assign grp_branch = inst_full & (op == rv_decode_pkg::OPC_BRANCH);
    assign grp_jal    = inst_full & (op == rv_decode_pkg::OPC_JAL);
    // other funct3 values of jalr are reserved
    assign grp_jalr   = inst_full & (op == rv_decode_pkg::OPC_JALR) & (funct3 == 3'b000);
    assign grp_sys    = inst_full & (op == rv_decode_pkg::OPC_SYSTEM);

    assign inst_trap   = grp_sys & (funct3 == 3'b000);
    assign inst_ecall  = inst_trap & (funct12 == rv_decode_pkg::SYS_ECALL);
    assign inst_ebreak = inst_trap & (funct12 == rv_decode_pkg::SYS_EBREAK);
    assign inst_mret   = inst_trap & (funct12 == rv_decode_pkg::SYS_MRET);
    // funct3 of 100 has no csr operation
    assign inst_csr    = grp_sys & (funct3[1:0] != 2'b00);

    assign supported = grp_load | grp_op_imm | grp_auipc | grp_store | grp_arith
                     | grp_mul | grp_lui | grp_branch | grp_jal | grp_jalr
                     | inst_ecall | inst_ebreak | inst_mret | inst_csr;

    // address computation
    assign alu_add = grp_load | grp_store | grp_auipc | grp_jal | grp_jalr;

    // branches and slt/sltu/slti/sltiu compare by subtraction
    assign alu_inv_force = grp_branch
                         | (grp_op_imm & (funct3[2:1] == 2'b01))
                         | (grp_arith & (funct3[2:1] == 2'b01));
    // op-imm has no sub, funct7 there is immediate
    assign alu_inv_clear = alu_add | grp_op_imm;

    assign o_cls.alu_ctrl = '{
        add_override: alu_add,
        op2_inverse:  alu_inv_force | (!alu_inv_clear & funct7[5]),
        sh_ar:        funct7[5],
        group_mux:    grp_mul,
        div_mux:      grp_mul & funct3[2]
    };

    assign o_cls.res_src = '{
        memory:  grp_load,
        pc_next: grp_jal | grp_jalr,
        alu:     !(grp_load | grp_jal | grp_jalr)
    };

    assign o_cls.supported   = supported;
    assign o_cls.reg_write   = supported & !(grp_store | grp_branch);
    assign o_cls.op1_pc      = grp_auipc | grp_jal;
    assign o_cls.op2_imm     = !((op == rv_decode_pkg::OPC_OP)
                                 | (op == rv_decode_pkg::OPC_BRANCH));
    assign o_cls.is_branch   = grp_branch;
    assign o_cls.is_jal      = grp_jal;
    assign o_cls.is_jalr     = grp_jalr;
    assign o_cls.is_store    = grp_store;
    assign o_cls.is_mret     = inst_mret;
    assign o_cls.is_ebreak   = inst_ebreak;
    assign o_cls.csr_req     = inst_csr;
    assign o_cls.csr_op      = inst_csr ? rv_decode_pkg::csr_op_t'(funct3[1:0])
                                        : rv_decode_pkg::CSR_NONE;
    assign o_cls.csr_imm_sel = funct3[2];

endmodule

/* logic/rv_operand_decode.sv */
module rv_operand_decode
(
    decode_bus_if.dst i_bus,
    operand_if.src    o_opd
);

    logic [rv_decode_pkg::XLEN-1:0] instr;
    logic [4:0]                     op;
    logic [rv_decode_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign instr = i_bus.instr;
    assign op    = instr[6:2];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign o_opd.imm = ((op == rv_decode_pkg::OPC_LUI)
                        || (op == rv_decode_pkg::OPC_AUIPC)) ? imm_u :
                       (op == rv_decode_pkg::OPC_JAL)        ? imm_j :
                       (op == rv_decode_pkg::OPC_STORE)      ? imm_s :
                       (op == rv_decode_pkg::OPC_BRANCH)     ? imm_b :
                                                               imm_i;

    assign o_opd.rd     = instr[11:7];
    // lui adds its immediate to x0
    assign o_opd.rs1    = (op == rv_decode_pkg::OPC_LUI) ? '0 : instr[19:15];
    assign o_opd.rs2    = instr[24:20];
    assign o_opd.funct3 = instr[14:12];

    assign o_opd.csr_idx = instr[31:20];
    assign o_opd.csr_imm = instr[19:15];

endmodule

/* logic/rv_decode_out.sv */
module rv_decode_out
(
    decode_bus_if.dst                           i_bus,
    class_if.dst                                i_cls,
    operand_if.dst                              i_opd,
    input  logic                                i_flush,
    output logic                                o_valid,
    output logic                                o_illegal,
    output logic                                o_reg_write,
    output logic                                o_op1_src,
    output logic                                o_op2_src,
    output logic                                o_inst_branch,
    output logic                                o_inst_jal,
    output logic                                o_inst_jalr,
    output logic                                o_inst_store,
    output logic                                o_inst_mret,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rs1,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rs2,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rd,
    output logic [rv_decode_pkg::XLEN-1:0]      o_imm,
    output logic [rv_decode_pkg::FUNCT3_W-1:0]  o_funct3,
    output logic [rv_decode_pkg::PC_BITS-1:1]   o_pc,
    output logic [rv_decode_pkg::PC_BITS-1:1]   o_pc_next,
    output rv_decode_pkg::alu_ctrl_t            o_alu_ctrl,
    output rv_decode_pkg::res_src_t             o_res_src,
    output logic [rv_decode_pkg::CSR_IDX_W-1:0] o_csr_idx,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_csr_imm,
    output logic                                o_csr_imm_sel,
    output logic                                o_csr_write,
    output logic                                o_csr_set,
    output logic                                o_csr_clear,
    output logic                                o_csr_read,
    output logic                                o_csr_ebreak
);

    logic valid;
    logic csr_commit;

    assign valid = i_bus.valid;
    // no csr side effects while the stage is being flushed
    assign csr_commit = valid & !i_flush;

    assign o_valid       = valid;
    assign o_illegal     = valid & !i_cls.supported;
    assign o_reg_write   = valid & i_cls.reg_write;
    assign o_inst_branch = valid & i_cls.is_branch;
    assign o_inst_jal    = valid & i_cls.is_jal;
    assign o_inst_jalr   = valid & i_cls.is_jalr;
    assign o_inst_store  = valid & i_cls.is_store;
    assign o_inst_mret   = valid & i_cls.is_mret;

    // empty stage reads as alu
    assign o_res_src = '{
        memory:  valid & i_cls.res_src.memory,
        pc_next: valid & i_cls.res_src.pc_next,
        alu:     !valid | i_cls.res_src.alu
    };

    assign o_csr_write  = csr_commit & (i_cls.csr_op == rv_decode_pkg::CSR_WRITE);
    assign o_csr_set    = csr_commit & (i_cls.csr_op == rv_decode_pkg::CSR_SET);
    assign o_csr_clear  = csr_commit & (i_cls.csr_op == rv_decode_pkg::CSR_CLEAR);
    assign o_csr_read   = valid & i_cls.csr_req;
    assign o_csr_ebreak = valid & i_cls.is_ebreak;

    assign o_op1_src     = i_cls.op1_pc;
    assign o_op2_src     = i_cls.op2_imm;
    assign o_alu_ctrl    = i_cls.alu_ctrl;
    assign o_csr_imm_sel = i_cls.csr_imm_sel;

    assign o_rs1     = i_opd.rs1;
    assign o_rs2     = i_opd.rs2;
    assign o_rd      = i_opd.rd;
    assign o_imm     = i_opd.imm;
    assign o_funct3  = i_opd.funct3;
    assign o_csr_idx = i_opd.csr_idx;
    assign o_csr_imm = i_opd.csr_imm;
    assign o_pc      = i_bus.pc;
    assign o_pc_next = i_bus.pc_next;

endmodule

/* logic/rv_decode_top.sv */
module rv_decode_top
(
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_stall,
    input  logic                                i_flush,
    input  logic                                i_ready,
    input  logic [rv_decode_pkg::XLEN-1:0]      i_instruction,
    input  logic [rv_decode_pkg::PC_BITS-1:1]   i_pc,
    input  logic [rv_decode_pkg::PC_BITS-1:1]   i_pc_next,
    output logic                                o_valid,
    output logic                                o_illegal,
    output logic                                o_reg_write,
    output logic                                o_op1_src,
    output logic                                o_op2_src,
    output logic                                o_inst_branch,
    output logic                                o_inst_jal,
    output logic                                o_inst_jalr,
    output logic                                o_inst_store,
    output logic                                o_inst_mret,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rs1,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rs2,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_rd,
    output logic [rv_decode_pkg::XLEN-1:0]      o_imm,
    output logic [rv_decode_pkg::FUNCT3_W-1:0]  o_funct3,
    output logic [rv_decode_pkg::PC_BITS-1:1]   o_pc,
    output logic [rv_decode_pkg::PC_BITS-1:1]   o_pc_next,
    output rv_decode_pkg::alu_ctrl_t            o_alu_ctrl,
    output rv_decode_pkg::res_src_t             o_res_src,
    output logic [rv_decode_pkg::CSR_IDX_W-1:0] o_csr_idx,
    output logic [rv_decode_pkg::REG_IDX_W-1:0] o_csr_imm,
    output logic                                o_csr_imm_sel,
    output logic                                o_csr_write,
    output logic                                o_csr_set,
    output logic                                o_csr_clear,
    output logic                                o_csr_read,
    output logic                                o_csr_ebreak
);

    decode_bus_if bus ();
    class_if      cls ();
    operand_if    opd ();

    rv_fetch_latch u_latch
    (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_ready       (i_ready),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .o_bus         (bus.src)
    );

    // both decoders work on the same latched word
    rv_class_decode u_class
    (
        .i_bus (bus.dst),
        .o_cls (cls.src)
    );

    rv_operand_decode u_operand
    (
        .i_bus (bus.dst),
        .o_opd (opd.src)
    );

    rv_decode_out u_out
    (
        .i_bus         (bus.dst),
        .i_cls         (cls.dst),
        .i_opd         (opd.dst),
        .i_flush       (i_flush),
        .o_valid       (o_valid),
        .o_illegal     (o_illegal),
        .o_reg_write   (o_reg_write),
        .o_op1_src     (o_op1_src),
        .o_op2_src     (o_op2_src),
        .o_inst_branch (o_inst_branch),
        .o_inst_jal    (o_inst_jal),
        .o_inst_jalr   (o_inst_jalr),
        .o_inst_store  (o_inst_store),
        .o_inst_mret   (o_inst_mret),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_imm         (o_imm),
        .o_funct3      (o_funct3),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_res_src     (o_res_src),
        .o_csr_idx     (o_csr_idx),
        .o_csr_imm     (o_csr_imm),
        .o_csr_imm_sel (o_csr_imm_sel),
        .o_csr_write   (o_csr_write),
        .o_csr_set     (o_csr_set),
        .o_csr_clear   (o_csr_clear),
        .o_csr_read    (o_csr_read),
        .o_csr_ebreak  (o_csr_ebreak)
    );

endmodule

/* dv/rv_decode_chk.sv */
module rv_decode_chk
(
    input logic       clk, i_arst_n,
    input logic       o_valid, o_illegal, o_reg_write, o_inst_store, o_inst_branch,
    input logic       o_inst_jal, o_inst_jalr, o_inst_mret, o_csr_ebreak,
    input logic       o_csr_write, o_csr_set, o_csr_clear, o_csr_read,
    input logic [2:0] o_res_src
);

    int fail_count = 0;

    logic any_strobe;

    assign any_strobe = |{o_illegal, o_reg_write, o_inst_store, o_inst_branch, o_inst_jal,
                          o_inst_jalr, o_inst_mret, o_csr_ebreak, o_csr_write, o_csr_set,
                          o_csr_clear, o_csr_read};

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    a_res_onehot: assert property (@(posedge clk) disable iff (!i_arst_n) $onehot(o_res_src))
        else count_failure("result source not one-hot");

    a_idle: assert property (@(posedge clk) disable iff (!i_arst_n) !o_valid |-> !any_strobe)
        else count_failure("strobe active while stage is empty");

    a_illegal_wr: assert property (@(posedge clk) disable iff (!i_arst_n)
                                   !(o_illegal && o_reg_write))
        else count_failure("illegal word requests a register write");

    a_csr_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
                                 $onehot0({o_csr_write, o_csr_set, o_csr_clear}))
        else count_failure("more than one csr write/set/clear strobe");

endmodule

bind rv_decode_top rv_decode_chk u_chk (.*);

/* dv/rv_decode_tb.sv */
module rv_decode_tb;

    localparam int RESET_CYCLES = 10;
    localparam int N_ARITH      = 12;
    localparam int N_FMT        = 3;
    // two cycles per presented word plus the flush and stall cycles
    localparam int TEST_CYCLES     = 2 * (N_ARITH + 7 * N_FMT + 17) + 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

    logic clk = 1'b0;
    logic i_arst_n, i_stall, i_flush, i_ready;
    logic [rv_decode_pkg::XLEN-1:0]      i_instruction;
    logic [rv_decode_pkg::PC_BITS-1:1]   i_pc, i_pc_next;
    logic o_valid, o_illegal, o_reg_write, o_op1_src, o_op2_src;
    logic o_inst_branch, o_inst_jal, o_inst_jalr, o_inst_store, o_inst_mret;
    logic [rv_decode_pkg::REG_IDX_W-1:0] o_rs1, o_rs2, o_rd, o_csr_imm;
    logic [rv_decode_pkg::XLEN-1:0]      o_imm;
    logic [rv_decode_pkg::FUNCT3_W-1:0]  o_funct3;
    logic [rv_decode_pkg::PC_BITS-1:1]   o_pc, o_pc_next;
    rv_decode_pkg::alu_ctrl_t            o_alu_ctrl;
    rv_decode_pkg::res_src_t             o_res_src;
    logic [rv_decode_pkg::CSR_IDX_W-1:0] o_csr_idx;
    logic o_csr_imm_sel, o_csr_write, o_csr_set, o_csr_clear, o_csr_read, o_csr_ebreak;

    logic [15:0] lfsr = 16'd24;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          err_mark;

    rv_decode_top u_dut (.*);

    always #4 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    // word is accepted at the next rising edge and sampled one falling edge later
    task automatic present(input logic [31:0] word, input logic ready);
        @(negedge clk);
        i_instruction = word;
        i_ready       = ready;
        i_pc          = take_bits(rv_decode_pkg::PC_BITS - 1);
        i_pc_next     = take_bits(rv_decode_pkg::PC_BITS - 1);
        @(negedge clk);
    endtask

    task automatic check_idle();
        compare("idle strobes",
                {o_valid, o_illegal, o_reg_write, o_inst_store, o_inst_branch, o_inst_jal,
                 o_inst_jalr, o_inst_mret, o_csr_write, o_csr_set, o_csr_clear, o_csr_read,
                 o_csr_ebreak}, '0);
        compare("o_res_src", o_res_src, 3'b001);
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (err_count == err_mark)
            $display("%s: ok", name);
        else
            $display("%s: %0d mismatches", name, err_count - err_mark);
    endtask

    task automatic reset_state();
        err_mark = err_count;
        repeat (RESET_CYCLES / 2) @(negedge clk);
        // addi x1, x0, 1
        i_instruction = 32'h0010_0093;
        check_idle();
        repeat (RESET_CYCLES / 2) @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);
        check_idle();
        report_test("reset");
    endtask

    task automatic arith_and_mul();
        logic [31:0] word;
        logic [4:0]  exp_alu;
        logic        is_imm, is_mul;
        err_mark = err_count;
        for (int n = 0; n < N_ARITH; n++)
        begin
            is_imm    = (n % 3 == 0);
            is_mul    = (n % 3 == 2);
            word      = take_bits(25) << 7;
            word[6:0] = {is_imm ? rv_decode_pkg::OPC_OP_IMM : rv_decode_pkg::OPC_OP, 2'b11};
            if (is_mul)
                word[31:25] = 7'b0000001;
            else if (!is_imm)
                word[31:25] = {1'b0, word[30], 5'b0};
            // compares and sub/sra invert operand two but the M unit never does
            exp_alu = {1'b0, !is_mul & ((word[14:13] == 2'b01) | (!is_imm & word[30])),
                       word[30], is_mul, is_mul & word[14]};
            present(word, 1'b1);
            compare("{o_reg_write,o_illegal,o_op2_src,o_res_src,o_alu_ctrl}",
                    {o_reg_write, o_illegal, o_op2_src, o_res_src, o_alu_ctrl},
                    {1'b1, 1'b0, is_imm, 3'b001, exp_alu});
            compare("{o_rs1,o_rs2,o_rd,o_funct3}", {o_rs1, o_rs2, o_rd, o_funct3},
                    {word[19:15], word[24:20], word[11:7], word[14:12]});
            compare("o_imm", o_imm, {{20{word[31]}}, word[31:20]});
        end
        report_test("arith_and_mul");
    endtask

    task automatic immediate_formats();
        logic [4:0]  kinds [7];
        logic [4:0]  opc;
        logic [31:0] word, imm, exp_imm;
        logic        ld, st, br, jmp, lui;
        err_mark = err_count;
        kinds = '{rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_STORE, rv_decode_pkg::OPC_BRANCH,
                  rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL,
                  rv_decode_pkg::OPC_JALR};
        for (int n = 0; n < 7 * N_FMT; n++)
        begin
            opc       = kinds[n % 7];
            word      = take_bits(25) << 7;
            word[6:0] = {opc, 2'b11};
            imm       = take_bits(32);
            // scatter a chosen immediate into its format
            case (opc)
                rv_decode_pkg::OPC_STORE:
                begin
                    exp_imm     = {{20{imm[11]}}, imm[11:0]};
                    word[31:25] = imm[11:5];
                    word[11:7]  = imm[4:0];
                end
                rv_decode_pkg::OPC_BRANCH:
                begin
                    exp_imm     = {{19{imm[12]}}, imm[12:1], 1'b0};
                    word[31:25] = {imm[12], imm[10:5]};
                    word[11:7]  = {imm[4:1], imm[11]};
                end
                rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC:
                begin
                    exp_imm     = {imm[31:12], 12'b0};
                    word[31:12] = imm[31:12];
                end
                rv_decode_pkg::OPC_JAL:
                begin
                    exp_imm     = {{11{imm[20]}}, imm[20:1], 1'b0};
                    word[31:12] = {imm[20], imm[10:1], imm[11], imm[19:12]};
                end
                default:
                begin
                    exp_imm     = {{20{imm[11]}}, imm[11:0]};
                    word[31:20] = imm[11:0];
                end
            endcase
            if (opc == rv_decode_pkg::OPC_JALR)
                word[14:12] = 3'b000;
            ld  = (opc == rv_decode_pkg::OPC_LOAD);
            st  = (opc == rv_decode_pkg::OPC_STORE);
            br  = (opc == rv_decode_pkg::OPC_BRANCH);
            lui = (opc == rv_decode_pkg::OPC_LUI);
            jmp = (opc == rv_decode_pkg::OPC_JAL) || (opc == rv_decode_pkg::OPC_JALR);
            present(word, 1'b1);
            compare("o_imm", o_imm, exp_imm);
            compare("o_rs1", o_rs1, lui ? 5'd0 : word[19:15]);
            compare("{o_reg_write,o_res_src,o_op1_src,o_op2_src,store,branch,jal,jalr,add}",
                    {o_reg_write, o_res_src, o_op1_src, o_op2_src, o_inst_store,
                     o_inst_branch, o_inst_jal, o_inst_jalr, o_alu_ctrl.add_override},
                    {!(st | br), ld, jmp, !(ld | jmp),
                     (opc == rv_decode_pkg::OPC_AUIPC) || (opc == rv_decode_pkg::OPC_JAL),
                     !br, st, br, opc == rv_decode_pkg::OPC_JAL,
                     opc == rv_decode_pkg::OPC_JALR, !(lui | br)});
            compare("{o_illegal,o_pc,o_pc_next}", {o_illegal, o_pc, o_pc_next},
                    {1'b0, i_pc, i_pc_next});
        end
        report_test("immediate_formats");
    endtask

    task automatic system_words();
        logic [31:0] word;
        logic [1:0]  op;
        err_mark = err_count;
        for (int f3 = 1; f3 < 8; f3++)
        begin
            if (f3 == 4)
                continue;
            word        = take_bits(25) << 7;
            word[14:12] = f3[2:0];
            word[6:0]   = {rv_decode_pkg::OPC_SYSTEM, 2'b11};
            op          = f3[1:0];
            present(word, 1'b1);
            compare("{o_csr_idx,o_csr_imm,o_csr_imm_sel}",
                    {o_csr_idx, o_csr_imm, o_csr_imm_sel}, {word[31:15], word[14]});
            compare("{o_csr_write,o_csr_set,o_csr_clear,o_csr_read}",
                    {o_csr_write, o_csr_set, o_csr_clear, o_csr_read},
                    {op == 2'd1, op == 2'd2, op == 2'd3, 1'b1});
            // same word still latched while flush is raised
            i_flush = 1'b1;
            #2;
            compare("csr strobes under flush", {o_csr_write, o_csr_set, o_csr_clear}, 3'b000);
            @(negedge clk);
            compare("o_valid after flush", o_valid, 1'b0);
            i_flush = 1'b0;
        end
        present({12'h001, 13'b0, rv_decode_pkg::OPC_SYSTEM, 2'b11}, 1'b1);
        compare("{o_csr_ebreak,o_illegal}", {o_csr_ebreak, o_illegal}, 2'b10);
        present({12'h302, 13'b0, rv_decode_pkg::OPC_SYSTEM, 2'b11}, 1'b1);
        compare("{o_inst_mret,o_illegal}", {o_inst_mret, o_illegal}, 2'b10);
        report_test("system_words");
    endtask

    task automatic illegal_words();
        logic [31:0] word;
        err_mark = err_count;
        for (int n = 0; n < 6; n++)
        begin
            word = take_bits(32);
            case (n)
                0, 1, 2: word[1:0] = n[1:0];
                // op-fp and flw
                3: word[6:0] = 7'b1010011;
                4: word[6:0] = 7'b0000111;
                default:
                begin
                    word[6:0] = {rv_decode_pkg::OPC_JALR, 2'b11};
                    word[12]  = 1'b1;
                end
            endcase
            present(word, 1'b1);
            compare("{o_valid,o_illegal,o_reg_write}", {o_valid, o_illegal, o_reg_write}, 3'b110);
        end
        report_test("illegal_words");
    endtask

    task automatic stall_and_flush();
        logic [31:0]                       first, second;
        logic [rv_decode_pkg::PC_BITS-1:1] first_pc;
        err_mark = err_count;
        first  = (take_bits(25) << 7) | {25'b0, rv_decode_pkg::OPC_OP_IMM, 2'b11};
        second = (take_bits(25) << 7) | {25'b0, rv_decode_pkg::OPC_LUI, 2'b11};
        present(first, 1'b1);
        first_pc      = i_pc;
        i_stall       = 1'b1;
        i_instruction = second;
        i_pc          = ~i_pc;
        repeat (2) @(negedge clk);
        compare("stalled {o_valid,o_rd,o_imm,o_pc}", {o_valid, o_rd, o_imm, o_pc},
                {1'b1, first[11:7], {{20{first[31]}}, first[31:20]}, first_pc});
        i_stall = 1'b0;
        @(negedge clk);
        compare("{o_valid,o_rd,o_imm}", {o_valid, o_rd, o_imm},
                {1'b1, second[11:7], second[31:12], 12'b0});
        // a full stage goes empty when loaded without ready
        present(first, 1'b0);
        check_idle();
        present(first, 1'b1);
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        check_idle();
        report_test("stall_and_flush");
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        i_arst_n      = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_pc_next     = '0;
        reset_state();
        arith_and_mul();
        immediate_formats();
        system_words();
        illegal_words();
        stall_and_flush();
        $display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 test_count, check_count, err_count, u_dut.u_chk.fail_count);
        if (err_count == 0 && u_dut.u_chk.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* filelist.f */
logic/rv_decode_pkg.sv
logic/rv_decode_if.sv
logic/rv_fetch_latch.sv
logic/rv_class_decode.sv
logic/rv_operand_decode.sv
logic/rv_decode_out.sv
logic/rv_decode_top.sv
dv/rv_decode_chk.sv
dv/rv_decode_tb.sv
